//--- common/servo_pkg.sv
// servo_pkg
// shared widths, fixed-point shifts and config types for the
// two-channel laser servo, plus the sample and SPI state types

`default_nettype none

package servo_pkg;

	////////////////////////////////////////
	// widths

	localparam int SAMPLE_W    = 16;
	localparam int SIGNAL_W    = 24;
	// iir coefficients, 3 integer bits over 32 fraction bits
	localparam int COEF_W      = 35;
	localparam int COEF_FRAC   = 32;
	localparam int GAIN_W      = 16;
	localparam int FAST_DAC_W  = 14;
	localparam int SLOW_DAC_W  = 20;
	localparam int SPI_FRAME_W = 24;

	// raw sample sits 8 bits up inside the signal word
	localparam int SAMPLE_SHIFT = SIGNAL_W - SAMPLE_W;

	// pi scaling
	localparam int KP_SHIFT = 8;
	localparam int KI_SHIFT = 12;

	// full-precision accumulators
	localparam int IIR_ACC_W = COEF_W + SIGNAL_W + 2;
	localparam int PI_PROD_W = GAIN_W + SIGNAL_W;
	localparam int PI_SUM_W  = PI_PROD_W + 1;

	// afe gain drive is inverted against the setting
	localparam logic [1:0] AFE_GAIN_MAX = 2'd3;

	// slow dac framing
	localparam logic [3:0] SLOW_DAC_WRITE_CMD = 4'd1;
	localparam int         SPI_FRAME_CYCLES   = 52;
	localparam int         SPI_CNT_W          = 6;

	////////////////////////////////////////
	// types

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [SIGNAL_W-1:0] signal_t;

	localparam signal_t SIGNAL_MAX = {1'b0, {(SIGNAL_W-1){1'b1}}};
	localparam signal_t SIGNAL_MIN = {1'b1, {(SIGNAL_W-1){1'b0}}};

	typedef struct packed {
		logic                     on;
		logic signed [COEF_W-1:0] a1;
		logic signed [COEF_W-1:0] b0;
		logic signed [COEF_W-1:0] b1;
	} iir_cfg_t;

	typedef struct packed {
		logic                     lock_on;
		logic signed [GAIN_W-1:0] kp;
		logic signed [GAIN_W-1:0] ki;
	} loop_cfg_t;

	typedef struct packed {
		iir_cfg_t [1:0]   iir;
		loop_cfg_t        loop;
		logic [1:0][1:0]  afe_gain;
	} servo_cfg_t;

	typedef struct packed {
		logic    valid;
		signal_t diff;
		signal_t control;
	} servo_sample_t;

	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		LOAD
	} spi_state_t;

endpackage

`default_nettype wire

//--- adc_front/adc_lowpass.sv
// adc_lowpass
// first-order iir low-pass for one adc channel
// y[n] = (b0*x[n] + b1*x[n-1] + a1*y[n-1]) >>> COEF_FRAC

`timescale 1ns/1ps
`default_nettype none

module adc_lowpass (
	input  wire                  i_clk1,
	input  wire                  i_reset,
	input  servo_pkg::iir_cfg_t  i_cfg,
	input  servo_pkg::sample_t   i_sample,
	input  wire                  i_valid,
	output servo_pkg::signal_t   o_signal,
	output logic                 o_valid
);

	import servo_pkg::*;

	// input scaled into the signal word
	signal_t x_cur;
	// history
	signal_t x_prev;
	signal_t y_prev;

	logic signed [IIR_ACC_W-1:0] acc;
	signal_t                     y_new;

	////////////////////////////////////////
	// filter step

	always_comb begin
		// sign extend, then 8 bits up
		x_cur = {i_sample, {SAMPLE_SHIFT{1'b0}}};
		// all three products kept at full width before the shift
		acc = i_cfg.b0 * x_cur + i_cfg.b1 * x_prev + i_cfg.a1 * y_prev;
		y_new = signal_t'(acc >>> COEF_FRAC);
	end

	////////////////////////////////////////
	// history and output

	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			x_prev  <= '0;
			y_prev  <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
			if (i_valid) begin
				x_prev <= x_cur;
				// bypass when off, history keeps running
				if (i_cfg.on) begin
					y_prev <= y_new;
				end else begin
					y_prev <= x_cur;
				end
			end
		end
	end

	// output is the last filtered value
	assign o_signal = y_prev;

endmodule

`default_nettype wire

//--- adc_front/adc_front.sv
// adc_front
// input side of the servo: registers the adc config, filters both
// channels, forms channel 0 minus channel 1, drives the afe gain pins

`timescale 1ns/1ps
`default_nettype none

module adc_front (
	input  wire                   i_clk1,
	input  wire                   i_reset,
	input  servo_pkg::servo_cfg_t i_cfg,
	input  servo_pkg::sample_t    i_adc0,
	input  servo_pkg::sample_t    i_adc1,
	input  wire                   i_adc_valid,
	output servo_pkg::signal_t    o_diff,
	output logic                  o_diff_valid,
	output logic [1:0]            o_afe_gain0,
	output logic [1:0]            o_afe_gain1
);

	import servo_pkg::*;

	// registered config slice
	iir_cfg_t [1:0]  iir_cfg_q;
	logic [1:0][1:0] afe_gain_q;

	sample_t adc [2];
	signal_t filt [2];
	logic    filt_valid [2];

	always_ff @(posedge i_clk1) begin
		iir_cfg_q  <= i_cfg.iir;
		afe_gain_q <= i_cfg.afe_gain;
	end

	// front-end amplifier code runs opposite to the gain setting
	assign o_afe_gain0 = AFE_GAIN_MAX - afe_gain_q[0];
	assign o_afe_gain1 = AFE_GAIN_MAX - afe_gain_q[1];

	assign adc[0] = i_adc0;
	assign adc[1] = i_adc1;

	////////////////////////////////////////
	// per-channel low-pass

	for (genvar ch = 0; ch < 2; ch++) begin : g_chan
		adc_lowpass i_lowpass (
			.i_clk1   (i_clk1),
			.i_reset  (i_reset),
			.i_cfg    (iir_cfg_q[ch]),
			.i_sample (adc[ch]),
			.i_valid  (i_adc_valid),
			.o_signal (filt[ch]),
			.o_valid  (filt_valid[ch])
		);
	end

	// error signal, one cycle behind the filters
	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			o_diff       <= '0;
			o_diff_valid <= 1'b0;
		end else begin
			o_diff_valid <= filt_valid[0] & filt_valid[1];
			if (filt_valid[0] && filt_valid[1]) begin
				o_diff <= filt[0] - filt[1];
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/pi_loop_filter.sv
// pi_loop_filter
// proportional-integral servo on the channel difference, with a
// saturating integrator and a lock enable

`timescale 1ns/1ps
`default_nettype none

module pi_loop_filter (
	input  wire                      i_clk1,
	input  wire                      i_reset,
	input  servo_pkg::loop_cfg_t     i_cfg,
	input  servo_pkg::signal_t       i_diff,
	input  wire                      i_diff_valid,
	output servo_pkg::servo_sample_t o_sample
);

	import servo_pkg::*;

	loop_cfg_t cfg_q;

	// integrator state
	signal_t integ_q;

	// output registers
	logic    valid_q;
	signal_t diff_q;
	signal_t control_q;

	logic signed [PI_PROD_W-1:0] p_prod;
	logic signed [PI_PROD_W-1:0] i_prod;
	logic signed [PI_SUM_W-1:0]  integ_sum;
	logic signed [PI_SUM_W-1:0]  ctrl_sum;
	signal_t                     integ_new;
	signal_t                     ctrl_new;

	// clamp a wide sum into the signal range
	function automatic signal_t sat(input logic signed [PI_SUM_W-1:0] v);
		if (v > SIGNAL_MAX) begin
			return SIGNAL_MAX;
		end else if (v < SIGNAL_MIN) begin
			return SIGNAL_MIN;
		end
		return signal_t'(v);
	endfunction

	always_ff @(posedge i_clk1) begin
		cfg_q <= i_cfg;
	end

	////////////////////////////////////////
	// pi arithmetic

	always_comb begin
		// error is the difference itself
		p_prod = cfg_q.kp * i_diff;
		i_prod = cfg_q.ki * i_diff;
		integ_sum = integ_q + (i_prod >>> KI_SHIFT);
		integ_new = sat(integ_sum);
		// p term rides on top of the updated integrator
		ctrl_sum = (p_prod >>> KP_SHIFT) + integ_new;
		ctrl_new = sat(ctrl_sum);
	end

	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			integ_q <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_diff_valid;
			if (!cfg_q.lock_on) begin
				// unlocked, integrator parked at zero
				integ_q <= '0;
			end else if (i_diff_valid) begin
				integ_q <= integ_new;
			end
		end
	end

	// payload
	always_ff @(posedge i_clk1) begin
		if (i_diff_valid) begin
			diff_q    <= i_diff;
			control_q <= cfg_q.lock_on ? ctrl_new : '0;
		end
	end

	// diff travels beside control for the monitor output
	assign o_sample = '{valid: valid_q, diff: diff_q, control: control_q};

endmodule

`default_nettype wire

//--- dac_out/fast_dac_port.sv
// fast_dac_port
// interleaved parallel port for the dual fast dac
// dci high carries control, dci low carries the difference

`timescale 1ns/1ps
`default_nettype none

module fast_dac_port (
	input  wire                      i_clk1,
	input  wire                      i_reset,
	input  servo_pkg::servo_sample_t i_sample,
	output logic [13:0]              o_dac_d,
	output logic                     o_dac_dci
);

	import servo_pkg::*;

	// latest sample
	signal_t ctrl_q;
	signal_t diff_q;

	signal_t ctrl_src;
	signal_t diff_src;

	// take a fresh sample straight through so it shows early
	assign ctrl_src = i_sample.valid ? i_sample.control : ctrl_q;
	assign diff_src = i_sample.valid ? i_sample.diff : diff_q;

	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			ctrl_q    <= '0;
			diff_q    <= '0;
			o_dac_dci <= 1'b0;
			o_dac_d   <= '0;
		end else begin
			ctrl_q    <= ctrl_src;
			diff_q    <= diff_src;
			o_dac_dci <= ~o_dac_dci;
			// word matches the dci level it goes out with
			if (!o_dac_dci) begin
				o_dac_d <= ctrl_src[SIGNAL_W-1 -: FAST_DAC_W];
			end else begin
				o_dac_d <= diff_src[SIGNAL_W-1 -: FAST_DAC_W];
			end
		end
	end

endmodule

`default_nettype wire

//--- dac_out/slow_dac_spi.sv
// slow_dac_spi
// writes the loop output to the 20-bit precision dac as 24-bit spi
// frames, then pulses ldac; newest sample waits in a pending slot

`timescale 1ns/1ps
`default_nettype none

module slow_dac_spi (
	input  wire                      i_clk1,
	input  wire                      i_reset,
	input  servo_pkg::servo_sample_t i_sample,
	output logic                     o_spi_scs,
	output logic                     o_spi_sck,
	output logic                     o_spi_sdi,
	output logic                     o_ldac
);

	import servo_pkg::*;

	spi_state_t state;

	logic [SPI_CNT_W-1:0]   cnt;
	logic [SPI_FRAME_W-1:0] shreg;

	// one-deep pending word
	logic [SLOW_DAC_W-1:0] pend_q;
	logic                  pend_valid;

	logic [SLOW_DAC_W-1:0] new_word;

	assign new_word  = i_sample.control[SIGNAL_W-1 -: SLOW_DAC_W];
	assign o_spi_sdi = shreg[SPI_FRAME_W-1];

	////////////////////////////////////////
	// pending slot

	always_ff @(posedge i_clk1) begin
		if (i_sample.valid) begin
			pend_q <= new_word;
		end
	end

	// only samples landing during a frame wait here
	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			pend_valid <= 1'b0;
		end else if (state == IDLE) begin
			pend_valid <= 1'b0;
		end else if (i_sample.valid) begin
			pend_valid <= 1'b1;
		end
	end

	////////////////////////////////////////
	// frame fsm
	// sck toggles for 48 cycles, scs rises at 50, ldac low at 52

	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			state     <= IDLE;
			cnt       <= '0;
			shreg     <= '0;
			o_spi_scs <= 1'b1;
			o_spi_sck <= 1'b0;
			o_ldac    <= 1'b1;
		end else begin
			unique case (state)
				IDLE: begin
					if (i_sample.valid || pend_valid) begin
						// fresh sample beats the pending one
						shreg <= {SLOW_DAC_WRITE_CMD,
							i_sample.valid ? new_word : pend_q};
						cnt       <= '0;
						o_spi_scs <= 1'b0;
						o_spi_sck <= 1'b0;
						state     <= SHIFT;
					end
				end
				SHIFT: begin
					cnt <= cnt + 1'b1;
					if (cnt < SPI_CNT_W'(2 * SPI_FRAME_W)) begin
						o_spi_sck <= ~o_spi_sck;
						// next bit on the falling edge
						if (o_spi_sck) begin
							shreg <= shreg << 1;
						end
					end
					if (cnt == SPI_CNT_W'(SPI_FRAME_CYCLES - 3)) begin
						o_spi_scs <= 1'b1;
					end
					if (cnt == SPI_CNT_W'(SPI_FRAME_CYCLES - 1)) begin
						o_ldac <= 1'b0;
						state  <= LOAD;
					end
				end
				LOAD: begin
					// single-cycle ldac
					o_ldac <= 1'b1;
					state  <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/servo_top.sv
// servo_top
// two-channel laser servo: adc front end, pi loop filter,
// fast monitor dac port and slow precision dac writer

`timescale 1ns/1ps
`default_nettype none

module servo_top (
	input  wire                   i_clk1,
	input  wire                   i_reset,
	input  servo_pkg::sample_t    i_adc0,
	input  servo_pkg::sample_t    i_adc1,
	input  wire                   i_adc_valid,
	input  servo_pkg::servo_cfg_t i_cfg,
	output logic [1:0]            o_afe_gain0,
	output logic [1:0]            o_afe_gain1,
	output logic [13:0]           o_dac_d,
	output logic                  o_dac_dci,
	output logic                  o_spi_scs,
	output logic                  o_spi_sck,
	output logic                  o_spi_sdi,
	output logic                  o_ldac
);

	import servo_pkg::*;

	signal_t       diff;
	logic          diff_valid;
	servo_sample_t loop_sample;

	////////////////////////////////////////
	// input side

	adc_front i_adc_front (
		.i_clk1       (i_clk1),
		.i_reset      (i_reset),
		.i_cfg        (i_cfg),
		.i_adc0       (i_adc0),
		.i_adc1       (i_adc1),
		.i_adc_valid  (i_adc_valid),
		.o_diff       (diff),
		.o_diff_valid (diff_valid),
		.o_afe_gain0  (o_afe_gain0),
		.o_afe_gain1  (o_afe_gain1)
	);

	// loop
	pi_loop_filter i_pi_loop_filter (
		.i_clk1       (i_clk1),
		.i_reset      (i_reset),
		.i_cfg        (i_cfg.loop),
		.i_diff       (diff),
		.i_diff_valid (diff_valid),
		.o_sample     (loop_sample)
	);

	////////////////////////////////////////
	// output side

	fast_dac_port i_fast_dac_port (
		.i_clk1    (i_clk1),
		.i_reset   (i_reset),
		.i_sample  (loop_sample),
		.o_dac_d   (o_dac_d),
		.o_dac_dci (o_dac_dci)
	);

	slow_dac_spi i_slow_dac_spi (
		.i_clk1    (i_clk1),
		.i_reset   (i_reset),
		.i_sample  (loop_sample),
		.o_spi_scs (o_spi_scs),
		.o_spi_sck (o_spi_sck),
		.o_spi_sdi (o_spi_sdi),
		.o_ldac    (o_ldac)
	);

endmodule

`default_nettype wire

//--- verification/servo_model.svh
// servo reference model
// channel low-pass, difference and saturating pi loop built from the
// servo rules, plus the fast dac word check

`ifndef SERVO_MODEL_SVH
`define SERVO_MODEL_SVH

// filter history per channel
logic signed [23:0] m_x_prev [2];
logic signed [23:0] m_y_prev [2];
// loop state and the latest results
logic signed [23:0] m_integ;
logic signed [23:0] m_diff;
logic signed [23:0] m_ctrl;
// every word the slow dac may legally carry
logic [19:0]        m_words [$];

// clamp into the 24-bit signal range
function automatic logic signed [23:0] clamp24(input longint v);
	if (v > 64'sd8388607) begin
		return 24'sh7fffff;
	end
	if (v < -64'sd8388608) begin
		return 24'sh800000;
	end
	return v[23:0];
endfunction

function automatic void model_reset();
	m_x_prev[0] = '0;
	m_x_prev[1] = '0;
	m_y_prev[0] = '0;
	m_y_prev[1] = '0;
	m_integ     = '0;
	m_diff      = '0;
	m_ctrl      = '0;
endfunction

// one iir step, history runs on even when bypassed
function automatic logic signed [23:0] lowpass_step(input int ch, input sample_t s,
		input iir_cfg_t c);
	logic signed [23:0] x;
	longint             acc;
	logic signed [23:0] y;
	// raw sample sits 8 bits up
	x = {s, 8'h00};
	acc = longint'(c.b0) * longint'(x) + longint'(c.b1) * longint'(m_x_prev[ch])
		+ longint'(c.a1) * longint'(m_y_prev[ch]);
	y = c.on ? acc[55:32] : x;
	m_x_prev[ch] = x;
	m_y_prev[ch] = y;
	return y;
endfunction

function automatic void model_sample(input sample_t a0, input sample_t a1,
		input servo_cfg_t c);
	logic signed [23:0] y0;
	logic signed [23:0] y1;
	longint             p_term;
	longint             i_term;
	y0     = lowpass_step(0, a0, c.iir[0]);
	y1     = lowpass_step(1, a1, c.iir[1]);
	m_diff = y0 - y1;
	p_term = (longint'(c.loop.kp) * longint'(m_diff)) >>> 8;
	i_term = (longint'(c.loop.ki) * longint'(m_diff)) >>> 12;
	if (c.loop.lock_on) begin
		m_integ = clamp24(longint'(m_integ) + i_term);
		m_ctrl  = clamp24(p_term + longint'(m_integ));
	end else begin
		// unlocked loop parks at zero
		m_integ = '0;
		m_ctrl  = '0;
	end
	m_words.push_back(m_ctrl[23:4]);
endfunction

// both words of one sample on the fast port
// valid at cycle three and both words by cycle five
task automatic check_dac_words(input logic [13:0] want_ctrl, input logic [13:0] want_diff);
	logic        seen_ctrl;
	logic        seen_diff;
	logic [13:0] got_ctrl;
	logic [13:0] got_diff;
	int          n;
	seen_ctrl = 1'b0;
	seen_diff = 1'b0;
	got_ctrl  = '0;
	got_diff  = '0;
	n         = 0;
	while (!(seen_ctrl && seen_diff) && n < 5) begin
		@(negedge clk1);
		n++;
		if (dac_dci && !seen_ctrl) begin
			got_ctrl  = dac_d;
			seen_ctrl = (dac_d == want_ctrl);
		end else if (!dac_dci && !seen_diff) begin
			got_diff  = dac_d;
			seen_diff = (dac_d == want_diff);
		end
	end
	check_value("o_dac_d with dci high", got_ctrl, want_ctrl);
	check_value("o_dac_d with dci low", got_diff, want_diff);
endtask

`endif

//--- verification/servo_tb.sv
// servo_tb
// testbench for the laser servo with lfsr stimulus against a
// reference model, fast dac word checks, spi frame decoder and afe checks

`timescale 1ns/1ps
`default_nettype none

module servo_tb;

	import servo_pkg::*;

	logic       clk1;
	logic       reset;
	sample_t    adc0;
	sample_t    adc1;
	logic       adc_valid;
	servo_cfg_t cfg;
	// staged config, driven on the next apply
	servo_cfg_t next_cfg;

	logic [1:0]  afe_gain0;
	logic [1:0]  afe_gain1;
	logic [13:0] dac_d;
	logic        dac_dci;
	logic        spi_scs;
	logic        spi_sck;
	logic        spi_sdi;
	logic        ldac;

	int          errors;
	int          checks;
	logic [31:0] lfsr_state;

	// spi decoder results
	int          spi_frames;
	logic [19:0] spi_last;

	servo_top i_dut (
		.i_clk1      (clk1),
		.i_reset     (reset),
		.i_adc0      (adc0),
		.i_adc1      (adc1),
		.i_adc_valid (adc_valid),
		.i_cfg       (cfg),
		.o_afe_gain0 (afe_gain0),
		.o_afe_gain1 (afe_gain1),
		.o_dac_d     (dac_d),
		.o_dac_dci   (dac_dci),
		.o_spi_scs   (spi_scs),
		.o_spi_sck   (spi_sck),
		.o_spi_sdi   (spi_sdi),
		.o_ldac      (ldac)
	);

	// 100 ns clock
	initial begin
		clk1 = 1'b0;
		forever begin
			#50 clk1 = ~clk1;
		end
	end

	////////////////////////////////////////
	// helpers

	// fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b          = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], b};
			r          = {r[30:0], b};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		assert (got == want) else begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, want);
		end
	endtask

	`include "servo_model.svh"

	// 15 bits keep the channel difference inside the signal range
	function automatic sample_t rand_sample();
		logic [31:0] r;
		r = take_bits(15);
		return {r[14], r[14:0]};
	endfunction

	task automatic send_sample(input sample_t a0, input sample_t a1);
		logic [31:0] gap;
		@(posedge clk1);
		#1;
		adc0      = a0;
		adc1      = a1;
		adc_valid = 1'b1;
		model_sample(a0, a1, cfg);
		@(posedge clk1);
		#1;
		adc_valid = 1'b0;
		check_dac_words(m_ctrl[23:10], m_diff[23:10]);
		// random idle gap
		gap = take_bits(3);
		repeat (gap) @(posedge clk1);
	endtask

	task automatic send_random();
		send_sample(rand_sample(), rand_sample());
	endtask

	task automatic set_gains(input int kp_bits, input int ki_bits);
		logic [31:0] r;
		r = take_bits(kp_bits);
		next_cfg.loop.kp = r[15:0];
		r = take_bits(ki_bits);
		next_cfg.loop.ki = r[15:0];
	endtask

	// pole in 0.5 to 0.75 with zeros splitting the rest for unity dc gain
	task automatic random_filter(input int ch);
		logic [31:0] r;
		longint      a1;
		longint      rest;
		longint      b0;
		r    = take_bits(30);
		a1   = 64'h8000_0000 + longint'(r);
		rest = 64'h1_0000_0000 - a1;
		b0   = rest >>> 1;
		next_cfg.iir[ch].on = 1'b1;
		next_cfg.iir[ch].a1 = a1[34:0];
		next_cfg.iir[ch].b0 = b0[34:0];
		next_cfg.iir[ch].b1 = rest[34:0] - b0[34:0];
	endtask

	// new config with fresh afe settings, then the gain pins are checked
	task automatic apply_config();
		logic [31:0] r;
		r = take_bits(4);
		next_cfg.afe_gain[0] = r[1:0];
		next_cfg.afe_gain[1] = r[3:2];
		@(posedge clk1);
		#1;
		cfg = next_cfg;
		if (!cfg.loop.lock_on) begin
			m_integ = '0;
		end
		repeat (2) @(posedge clk1);
		@(negedge clk1);
		check_value("o_afe_gain0", afe_gain0, 2'd3 - cfg.afe_gain[0]);
		check_value("o_afe_gain1", afe_gain1, 2'd3 - cfg.afe_gain[1]);
	endtask

	// idle means scs and ldac high for longer than any frame gap
	task automatic wait_spi_idle();
		int quiet;
		int n;
		quiet = 0;
		n     = 0;
		while (quiet < 64 && n < 600) begin
			@(negedge clk1);
			n++;
			if (spi_scs && ldac) begin
				quiet++;
			end else begin
				quiet = 0;
			end
		end
		checks++;
		assert (quiet >= 64) else begin
			errors++;
			$display("spi writer never went idle after the last sample");
		end
	endtask

	////////////////////////////////////////
	// spi decoder

	// bits taken on rising sck and the frame closes when scs rises
	initial begin : spi_decoder
		logic [23:0] frame;
		int          bits;
		logic        scs_prev;
		logic        sck_prev;
		logic        found;
		logic        loaded;
		int          n;
		spi_frames = 0;
		spi_last   = '0;
		frame      = '0;
		bits       = 0;
		scs_prev   = 1'b1;
		sck_prev   = 1'b0;
		forever begin
			@(negedge clk1);
			if (!spi_scs && scs_prev) begin
				frame = '0;
				bits  = 0;
			end
			if (!spi_scs && spi_sck && !sck_prev) begin
				frame = {frame[22:0], spi_sdi};
				bits++;
			end
			if (spi_scs && !scs_prev) begin
				check_value("spi frame bit count", bits, 24);
				check_value("spi command bits", frame[23:20], 1);
				spi_frames++;
				spi_last = frame[19:0];
				found    = 1'b0;
				foreach (m_words[i]) begin
					if (m_words[i] == frame[19:0]) begin
						found = 1'b1;
					end
				end
				checks++;
				assert (found) else begin
					errors++;
					$display("CHECK FAILED o_spi_sdi data: got %h matching no model control",
						frame[19:0]);
				end
				// ldac low two cycles after scs
				loaded = 1'b0;
				n      = 0;
				while (!loaded && n < 4) begin
					@(negedge clk1);
					n++;
					loaded = !ldac;
				end
				checks++;
				assert (loaded) else begin
					errors++;
					$display("ldac did not pulse after the spi frame ended");
				end
			end
			scs_prev = spi_scs;
			sck_prev = spi_sck;
		end
	end

	////////////////////////////////////////
	// main sequence

	initial begin
		errors     = 0;
		checks     = 0;
		lfsr_state = 32'hc28;
		reset      = 1'b1;
		adc0       = '0;
		adc1       = '0;
		adc_valid  = 1'b0;
		cfg        = '0;
		next_cfg   = '0;
		model_reset();
		repeat (8) @(posedge clk1);
		#1;
		reset = 1'b0;

		// idle outputs right after reset
		repeat (2) @(negedge clk1);
		check_value("o_spi_scs", spi_scs, 1);
		check_value("o_spi_sck", spi_sck, 0);
		check_value("o_ldac", ldac, 1);
		check_value("o_dac_d", dac_d, 0);

		// filters bypassed and loop locked with modest gains
		next_cfg.loop.lock_on = 1'b1;
		set_gains(8, 6);
		apply_config();
		repeat (20) send_random();

		// both filters on
		for (int k = 0; k < 2; k++) begin
			random_filter(0);
			random_filter(1);
			apply_config();
			repeat (15) send_random();
		end

		// large errors push the loop into both clamps
		next_cfg.iir[0].on = 1'b0;
		next_cfg.iir[1].on = 1'b0;
		next_cfg.loop.kp   = 16'h7fff;
		next_cfg.loop.ki   = 16'h7fff;
		apply_config();
		repeat (4) send_sample(16'sh3fff, -16'sh4000);
		repeat (4) send_sample(-16'sh4000, 16'sh3fff);

		// unlocked then locked again
		next_cfg.loop.lock_on = 1'b0;
		apply_config();
		repeat (4) send_random();
		next_cfg.loop.lock_on = 1'b1;
		set_gains(8, 6);
		apply_config();
		repeat (6) send_random();

		// last frame carries the last control
		wait_spi_idle();
		checks++;
		assert (spi_frames > 0) else begin
			errors++;
			$display("no spi frame was seen during the run");
		end
		check_value("o_spi_sdi last frame data", spi_last, m_ctrl[23:4]);

		$display("checks %0d, errors %0d, spi frames %0d", checks, errors, spi_frames);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verification
common/servo_pkg.sv
adc_front/adc_lowpass.sv
adc_front/adc_front.sv
logic/pi_loop_filter.sv
dac_out/fast_dac_port.sv
dac_out/slow_dac_spi.sv
logic/servo_top.sv
verification/servo_tb.sv

//--- Bender.yml
package:
  name: laser_servo

sources:
  - common/servo_pkg.sv
  - adc_front/adc_lowpass.sv
  - adc_front/adc_front.sv
  - logic/pi_loop_filter.sv
  - dac_out/fast_dac_port.sv
  - dac_out/slow_dac_spi.sv
  - logic/servo_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/servo_tb.sv
